//--- logic/core_pkg.sv
package core_pkg;

    // ******************************
    // widths
    // ******************************
    localparam int XLEN       = 64;
    localparam int INST_W     = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [INST_W-1:0]     inst_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // ******************************
    // encodings
    // ******************************
    // RV major opcodes kept by this core
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SLT  = 4'd7,
        ALU_PASS = 4'd8
    } alu_op_e;

    // ******************************
    // stage payloads
    // ******************************
    typedef struct packed {
        xlen_t pc;
        inst_t inst;
    } fetch_t;

    typedef struct packed {
        xlen_t     pc;
        inst_t     inst;
        alu_op_e   alu_op;
        xlen_t     op1;
        xlen_t     op2;
        logic      rd_we;
        reg_addr_t rd;
    } exec_t;

    // also used as the forwarding record from execute and commit
    typedef struct packed {
        xlen_t     pc;
        inst_t     inst;
        logic      rd_we;
        reg_addr_t rd;
        xlen_t     wdata;
    } commit_t;

endpackage

//--- logic/reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic                clk,
    input  core_pkg::reg_addr_t raddr1_i,
    input  core_pkg::reg_addr_t raddr2_i,
    input  logic                wr_en_i,
    input  core_pkg::reg_addr_t wr_addr_i,
    input  core_pkg::xlen_t     wr_data_i,
    output core_pkg::xlen_t     rdata1_o,
    output core_pkg::xlen_t     rdata2_o
);

    // x0 has no storage
    core_pkg::xlen_t regs [1:31];

    always_ff @(posedge clk) begin
        if (wr_en_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

//--- logic/inst_queue.sv
`timescale 1ns/10ps

module inst_queue #(
    parameter int              QUEUE_DEPTH = 4,
    parameter core_pkg::xlen_t RESET_PC    = 64'h0000_0000_8000_0000
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              inst_valid_i,
    input  core_pkg::inst_t   inst_i,
    input  logic              pop_i,
    output core_pkg::fetch_t  head_o,
    output logic              head_valid_o,
    output logic              credit_o
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    core_pkg::fetch_t  mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [CNT_W-1:0]  count_q;
    core_pkg::xlen_t   pc_q;
    logic              credit_q;
    logic              pop;

    // the sender only pushes while it holds a credit, so no full check
    assign pop          = pop_i && (count_q != '0);
    assign head_o       = mem[rd_ptr_q];
    assign head_valid_o = (count_q != '0);
    assign credit_o     = credit_q;

    always_ff @(posedge clk) begin
        if (inst_valid_i) begin
            mem[wr_ptr_q].pc   <= pc_q;
            mem[wr_ptr_q].inst <= inst_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            pc_q     <= RESET_PC;
            credit_q <= 1'b0;
        end else begin
            if (inst_valid_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
                pc_q     <= pc_q + 64'd4;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({inst_valid_i, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            // one credit back per popped entry
            credit_q <= pop;
        end
    end

endmodule

//--- logic/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
    input  logic                clk,
    input  logic                rst_n_i,
    input  core_pkg::fetch_t    head_i,
    input  logic                head_valid_i,
    input  logic                hold_i,
    input  core_pkg::commit_t   ex_fwd_i,
    input  logic                ex_fwd_valid_i,
    input  core_pkg::commit_t   cm_fwd_i,
    input  logic                cm_fwd_valid_i,
    input  logic                wr_en_i,
    input  core_pkg::reg_addr_t wr_addr_i,
    input  core_pkg::xlen_t     wr_data_i,
    output logic                pop_o,
    output core_pkg::exec_t     exec_o,
    output logic                exec_valid_o
);

    core_pkg::opcode_e   opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    core_pkg::reg_addr_t rs1;
    core_pkg::reg_addr_t rs2;
    core_pkg::reg_addr_t rd;
    core_pkg::xlen_t     imm_i;
    core_pkg::xlen_t     imm_u;
    core_pkg::xlen_t     rf_rdata1;
    core_pkg::xlen_t     rf_rdata2;
    core_pkg::xlen_t     src1;
    core_pkg::xlen_t     src2;
    core_pkg::exec_t     exec_d;
    core_pkg::exec_t     exec_q;
    logic                exec_valid_q;

    // youngest producer wins, x0 never forwarded
    function automatic core_pkg::xlen_t fwd_operand(
        input core_pkg::reg_addr_t addr,
        input core_pkg::xlen_t     rf_val,
        input core_pkg::commit_t   ex_rec,
        input logic                ex_vld,
        input core_pkg::commit_t   cm_rec,
        input logic                cm_vld
    );
        core_pkg::xlen_t val;
        val = rf_val;
        if (addr != '0) begin
            if (ex_vld && (ex_rec.rd == addr)) begin
                val = ex_rec.wdata;
            end else if (cm_vld && (cm_rec.rd == addr)) begin
                val = cm_rec.wdata;
            end
        end
        return val;
    endfunction

    assign opcode = core_pkg::opcode_e'(head_i.inst[6:0]);
    assign rd     = head_i.inst[11:7];
    assign funct3 = head_i.inst[14:12];
    assign rs1    = head_i.inst[19:15];
    assign rs2    = head_i.inst[24:20];
    assign funct7 = head_i.inst[31:25];
    assign imm_i  = {{52{head_i.inst[31]}}, head_i.inst[31:20]};
    assign imm_u  = {{32{head_i.inst[31]}}, head_i.inst[31:12], 12'b0};

    reg_file u_reg_file (
        .clk       ( clk       ),
        .raddr1_i  ( rs1       ),
        .raddr2_i  ( rs2       ),
        .wr_en_i   ( wr_en_i   ),
        .wr_addr_i ( wr_addr_i ),
        .wr_data_i ( wr_data_i ),
        .rdata1_o  ( rf_rdata1 ),
        .rdata2_o  ( rf_rdata2 )
    );

    assign src1 = fwd_operand(rs1, rf_rdata1, ex_fwd_i, ex_fwd_valid_i, cm_fwd_i, cm_fwd_valid_i);
    assign src2 = fwd_operand(rs2, rf_rdata2, ex_fwd_i, ex_fwd_valid_i, cm_fwd_i, cm_fwd_valid_i);

    always_comb begin
        exec_d.pc     = head_i.pc;
        exec_d.inst   = head_i.inst;
        exec_d.op1    = src1;
        exec_d.op2    = src2;
        exec_d.rd     = rd;
        exec_d.alu_op = core_pkg::ALU_PASS;
        exec_d.rd_we  = 1'b0;
        case (opcode)
            core_pkg::OPC_OP_IMM: begin
                exec_d.op2 = imm_i;
                if (funct3 == 3'b000) begin
                    exec_d.alu_op = core_pkg::ALU_ADD;
                    exec_d.rd_we  = 1'b1;
                end
            end
            core_pkg::OPC_OP: begin
                exec_d.rd_we = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: exec_d.alu_op = core_pkg::ALU_ADD;
                    10'b0100000_000: exec_d.alu_op = core_pkg::ALU_SUB;
                    10'b0000000_001: exec_d.alu_op = core_pkg::ALU_SLL;
                    10'b0000000_010: exec_d.alu_op = core_pkg::ALU_SLT;
                    10'b0000000_100: exec_d.alu_op = core_pkg::ALU_XOR;
                    10'b0000000_101: exec_d.alu_op = core_pkg::ALU_SRL;
                    10'b0000000_110: exec_d.alu_op = core_pkg::ALU_OR;
                    10'b0000000_111: exec_d.alu_op = core_pkg::ALU_AND;
                    default:         exec_d.rd_we  = 1'b0;
                endcase
            end
            core_pkg::OPC_LUI: begin
                exec_d.op2   = imm_u;
                exec_d.rd_we = 1'b1;
            end
            default: begin
                exec_d.rd_we = 1'b0;
            end
        endcase
        if (rd == '0) begin
            exec_d.rd_we = 1'b0;
        end
    end

    // ******************************
    // decode/execute register
    // ******************************
    assign pop_o = head_valid_i && !hold_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            exec_valid_q <= 1'b0;
        end else if (!hold_i) begin
            exec_valid_q <= head_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_i) begin
            exec_q <= exec_d;
        end
    end

    assign exec_o       = exec_q;
    assign exec_valid_o = exec_valid_q;

endmodule

//--- logic/alu_stage.sv
`timescale 1ns/10ps

module alu_stage (
    input  logic              clk,
    input  logic              rst_n_i,
    input  core_pkg::exec_t   exec_i,
    input  logic              exec_valid_i,
    input  logic              hold_i,
    output core_pkg::commit_t ex_fwd_o,
    output logic              ex_fwd_valid_o,
    output core_pkg::commit_t commit_o,
    output logic              commit_pending_o
);

    core_pkg::xlen_t   result;
    core_pkg::commit_t ex_rec;
    core_pkg::commit_t rec_q;
    logic              pending_q;

    always_comb begin
        case (exec_i.alu_op)
            core_pkg::ALU_ADD: result = exec_i.op1 + exec_i.op2;
            core_pkg::ALU_SUB: result = exec_i.op1 - exec_i.op2;
            core_pkg::ALU_AND: result = exec_i.op1 & exec_i.op2;
            core_pkg::ALU_OR:  result = exec_i.op1 | exec_i.op2;
            core_pkg::ALU_XOR: result = exec_i.op1 ^ exec_i.op2;
            // shift amount is op2[5:0] for RV64
            core_pkg::ALU_SLL: result = exec_i.op1 << exec_i.op2[5:0];
            core_pkg::ALU_SRL: result = exec_i.op1 >> exec_i.op2[5:0];
            core_pkg::ALU_SLT: result = {63'b0, $signed(exec_i.op1) < $signed(exec_i.op2)};
            default:           result = exec_i.op2;
        endcase
    end

    always_comb begin
        ex_rec.pc    = exec_i.pc;
        ex_rec.inst  = exec_i.inst;
        ex_rec.rd_we = exec_i.rd_we;
        ex_rec.rd    = exec_i.rd;
        ex_rec.wdata = result;
    end

    assign ex_fwd_o       = ex_rec;
    assign ex_fwd_valid_o = exec_valid_i && exec_i.rd_we;

    // ******************************
    // execute/commit register
    // ******************************
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pending_q <= 1'b0;
        end else if (!hold_i) begin
            pending_q <= exec_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_i) begin
            rec_q <= ex_rec;
        end
    end

    assign commit_o         = rec_q;
    assign commit_pending_o = pending_q;

endmodule

//--- logic/commit_port.sv
`timescale 1ns/10ps

module commit_port #(
    parameter int OUT_CREDITS = 2
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  core_pkg::commit_t   rec_i,
    input  logic                rec_pending_i,
    input  logic                credit_i,
    output core_pkg::commit_t   commit_o,
    output logic                commit_valid_o,
    output logic                hold_o,
    output logic                wr_en_o,
    output core_pkg::reg_addr_t wr_addr_o,
    output core_pkg::xlen_t     wr_data_o,
    output core_pkg::commit_t   cm_fwd_o,
    output logic                cm_fwd_valid_o
);

    localparam int CNT_W = (OUT_CREDITS > 0) ? $clog2(OUT_CREDITS + 1) : 1;

    logic [CNT_W-1:0] credit_cnt_q;
    logic             issue;

    assign issue  = rec_pending_i && (credit_cnt_q != '0);
    // waiting record with no credit stalls everything behind it
    assign hold_o = rec_pending_i && (credit_cnt_q == '0);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            credit_cnt_q <= CNT_W'(OUT_CREDITS);
        end else begin
            case ({credit_i, issue})
                2'b10:   credit_cnt_q <= credit_cnt_q + 1'b1;
                2'b01:   credit_cnt_q <= credit_cnt_q - 1'b1;
                default: credit_cnt_q <= credit_cnt_q;
            endcase
        end
    end

    assign commit_o       = rec_i;
    assign commit_valid_o = issue;

    // register write lands at the end of the issue cycle
    assign wr_en_o   = issue && rec_i.rd_we;
    assign wr_addr_o = rec_i.rd;
    assign wr_data_o = rec_i.wdata;

    // not yet in the register file until it issues
    assign cm_fwd_o       = rec_i;
    assign cm_fwd_valid_o = rec_pending_i && rec_i.rd_we;

endmodule

//--- logic/core_top.sv
`timescale 1ns/10ps

module core_top #(
    parameter int              QUEUE_DEPTH = 4,
    parameter int              OUT_CREDITS = 2,
    parameter core_pkg::xlen_t RESET_PC    = 64'h0000_0000_8000_0000
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              inst_valid_i,
    input  core_pkg::inst_t   inst_i,
    input  logic              credit_i,
    output logic              credit_o,
    output logic              commit_valid_o,
    output core_pkg::commit_t commit_o
);

    // ******************************
    // input side
    // ******************************
    core_pkg::fetch_t head;
    logic             head_valid;
    logic             pop;

    inst_queue #(
        .QUEUE_DEPTH ( QUEUE_DEPTH ),
        .RESET_PC    ( RESET_PC    )
    ) u_inst_queue (
        .clk          ( clk          ),
        .rst_n_i      ( rst_n_i      ),
        .inst_valid_i ( inst_valid_i ),
        .inst_i       ( inst_i       ),
        .pop_i        ( pop          ),
        .head_o       ( head         ),
        .head_valid_o ( head_valid   ),
        .credit_o     ( credit_o     )
    );

    // ******************************
    // decode and execute
    // ******************************
    core_pkg::exec_t     exec;
    logic                exec_valid;
    core_pkg::commit_t   ex_fwd;
    logic                ex_fwd_valid;
    core_pkg::commit_t   cm_fwd;
    logic                cm_fwd_valid;
    core_pkg::commit_t   rec;
    logic                rec_pending;
    logic                hold;
    logic                wr_en;
    core_pkg::reg_addr_t wr_addr;
    core_pkg::xlen_t     wr_data;

    decode_stage u_decode_stage (
        .clk            ( clk          ),
        .rst_n_i        ( rst_n_i      ),
        .head_i         ( head         ),
        .head_valid_i   ( head_valid   ),
        .hold_i         ( hold         ),
        .ex_fwd_i       ( ex_fwd       ),
        .ex_fwd_valid_i ( ex_fwd_valid ),
        .cm_fwd_i       ( cm_fwd       ),
        .cm_fwd_valid_i ( cm_fwd_valid ),
        .wr_en_i        ( wr_en        ),
        .wr_addr_i      ( wr_addr      ),
        .wr_data_i      ( wr_data      ),
        .pop_o          ( pop          ),
        .exec_o         ( exec         ),
        .exec_valid_o   ( exec_valid   )
    );

    alu_stage u_alu_stage (
        .clk              ( clk          ),
        .rst_n_i          ( rst_n_i      ),
        .exec_i           ( exec         ),
        .exec_valid_i     ( exec_valid   ),
        .hold_i           ( hold         ),
        .ex_fwd_o         ( ex_fwd       ),
        .ex_fwd_valid_o   ( ex_fwd_valid ),
        .commit_o         ( rec          ),
        .commit_pending_o ( rec_pending  )
    );

    // ******************************
    // output side
    // ******************************
    commit_port #(
        .OUT_CREDITS ( OUT_CREDITS )
    ) u_commit_port (
        .clk            ( clk            ),
        .rst_n_i        ( rst_n_i        ),
        .rec_i          ( rec            ),
        .rec_pending_i  ( rec_pending    ),
        .credit_i       ( credit_i       ),
        .commit_o       ( commit_o       ),
        .commit_valid_o ( commit_valid_o ),
        .hold_o         ( hold           ),
        .wr_en_o        ( wr_en          ),
        .wr_addr_o      ( wr_addr        ),
        .wr_data_o      ( wr_data        ),
        .cm_fwd_o       ( cm_fwd         ),
        .cm_fwd_valid_o ( cm_fwd_valid   )
    );

endmodule

//--- verification/core_tb_tests.svh
`ifndef CORE_TB_TESTS_SVH
`define CORE_TB_TESTS_SVH

// ******************************
// directed tests
// ******************************
task automatic reset_behavior();
    int err_before;
    err_before = errors;
    rst_n_i    = 1'b0;
    repeat (2) begin
        @(negedge clk);
        check_flag("commit_valid_o in reset", commit_valid_o, 1'b0);
        check_flag("credit_o in reset", credit_o, 1'b0);
    end
    rst_n_i = 1'b1;
    repeat (2) begin
        @(negedge clk);
        check_flag("commit_valid_o after reset", commit_valid_o, 1'b0);
        check_flag("credit_o after reset", credit_o, 1'b0);
    end
    report_test("reset", err_before);
endtask

// first fills every register for the later tests
task automatic addi_stream();
    int err_before;
    err_before = errors;
    for (int r = 1; r < 32; r++) begin
        send_inst(enc_i(rand_imm12(), 5'd0, 3'b000, 5'(r)));
    end
    for (int k = 31; k < N_ADDI; k++) begin
        send_inst(enc_i(rand_imm12(), rand_reg(), 3'b000, rand_reg()));
    end
    wait_drain();
    report_test("addi_stream", err_before);
endtask

// hist[0] sits in execute, hist[1] in commit, hist[2] already in the register file
task automatic dependent_chain();
    int                  err_before;
    core_pkg::reg_addr_t hist [3];
    core_pkg::reg_addr_t rd;
    core_pkg::reg_addr_t rs1;
    core_pkg::reg_addr_t rs2;
    core_pkg::inst_t     inst;
    err_before = errors;
    hist       = '{5'd1, 5'd2, 5'd3};
    for (int k = 0; k < N_CHAIN; k++) begin
        rd  = rand_reg();
        rs1 = hist[0];
        case (k % 4)
            0:       rs2 = hist[1];
            1:       rs2 = hist[2];
            2:       rs2 = rand_reg();
            default: begin
                rs1 = hist[1];
                rs2 = hist[0];
            end
        endcase
        case (k % 9)
            0:       inst = enc_r(7'h00, 3'b000, rd, rs1, rs2);
            1:       inst = enc_r(7'h20, 3'b000, rd, rs1, rs2);
            2:       inst = enc_r(7'h00, 3'b111, rd, rs1, rs2);
            3:       inst = enc_r(7'h00, 3'b110, rd, rs1, rs2);
            4:       inst = enc_r(7'h00, 3'b100, rd, rs1, rs2);
            5:       inst = enc_r(7'h00, 3'b001, rd, rs1, rs2);
            6:       inst = enc_r(7'h00, 3'b101, rd, rs1, rs2);
            7:       inst = enc_r(7'h00, 3'b010, rd, rs1, rs2);
            default: inst = enc_u(rand_imm20(), rd);
        endcase
        send_inst(inst);
        hist[2] = hist[1];
        hist[1] = hist[0];
        hist[0] = rd;
    end
    wait_drain();
    report_test("dependent_chain", err_before);
endtask

// each reader follows its skipped write by one or two slots
task automatic x0_and_unsupported();
    int err_before;
    err_before = errors;
    send_inst(enc_i(12'h7ff, 5'd5, 3'b000, 5'd0));
    send_inst(enc_r(7'h00, 3'b000, 5'd0, 5'd1, 5'd2));
    send_inst(enc_u(20'hfffff, 5'd0));
    send_inst(enc_r(7'h00, 3'b000, 5'd13, 5'd0, 5'd0));
    // load opcode is not part of this core
    send_inst({12'h010, 5'd3, 3'b011, 5'd7, 7'b0000011});
    send_inst(enc_r(7'h00, 3'b000, 5'd10, 5'd7, 5'd0));
    send_inst(enc_i(12'h004, 5'd4, 3'b001, 5'd8));
    send_inst(enc_r(7'h01, 3'b000, 5'd9, 5'd5, 5'd6));
    send_inst(enc_i(12'h000, 5'd8, 3'b000, 5'd11));
    send_inst(enc_r(7'h00, 3'b110, 5'd12, 5'd9, 5'd0));
    wait_drain();
    report_test("x0_and_unsupported", err_before);
endtask

task automatic output_backpressure();
    int err_before;
    int commits_before;
    err_before     = errors;
    commits_before = commits;
    auto_return    = 1'b0;
    send_inst(enc_i(rand_imm12(), 5'd0, 3'b000, 5'd14));
    for (int k = 1; k < N_BP; k++) begin
        send_inst(enc_i(12'h003, 5'd14, 3'b000, 5'd14));
    end
    // ample time for every record to reach commit
    repeat (20) @(negedge clk);
    check_credits("commits with credit_i withheld", commits - commits_before, OUT_CREDITS);
    check_flag("commit_valid_o with no credit", commit_valid_o, 1'b0);
    auto_return = 1'b1;
    wait_drain();
    check_credits("commits after credit return", commits - commits_before, N_BP);
    report_test("output_backpressure", err_before);
endtask

task automatic input_credit_stream();
    int              err_before;
    int              sent_before;
    int              returned_before;
    int              gap;
    core_pkg::inst_t inst;
    err_before      = errors;
    sent_before     = sent;
    returned_before = returned;
    for (int k = 0; k < N_RAND; k++) begin
        if (k % 2 == 0) begin
            inst = enc_i(rand_imm12(), rand_reg(), 3'b000, rand_reg());
        end else begin
            inst = enc_r(7'h00, 3'b000, rand_reg(), rand_reg(), rand_reg());
        end
        send_inst(inst);
        gap = $unsigned($random(seed)) % 3;
        repeat (gap) @(negedge clk);
    end
    wait_drain();
    check_credits("credit_o pulses", returned - returned_before, sent - sent_before);
    report_test("input_credit_stream", err_before);
endtask

`endif

//--- verification/core_tb.sv
`timescale 1ns/10ps

module core_tb;

    localparam int              QUEUE_DEPTH = 4;
    localparam int              OUT_CREDITS = 2;
    localparam core_pkg::xlen_t RESET_PC    = 64'h0000_0000_8000_0000;

    // instructions per test and the watchdog length built from them
    localparam int N_ADDI      = 40;
    localparam int N_CHAIN     = 36;
    localparam int N_X0        = 10;
    localparam int N_BP        = 6;
    localparam int N_RAND      = 30;
    localparam int N_TOTAL     = N_ADDI + N_CHAIN + N_X0 + N_BP + N_RAND;
    localparam int WATCHDOG_NS = N_TOTAL * 20 * 8 + 1000;

    logic              clk;
    logic              rst_n_i;
    logic              inst_valid_i;
    core_pkg::inst_t   inst_i;
    logic              credit_i;
    logic              credit_o;
    logic              commit_valid_o;
    core_pkg::commit_t commit_o;

    int seed = 32'h0e142017;

    // reference model state
    core_pkg::xlen_t   model_regs [32];
    core_pkg::xlen_t   model_pc;
    core_pkg::commit_t exp_q [$];

    int errors   = 0;
    int checks   = 0;
    int commits  = 0;
    int sent     = 0;
    int accepted = 0;
    int returned = 0;
    int owed     = 0;
    bit auto_return;

    core_top #(
        .QUEUE_DEPTH ( QUEUE_DEPTH ),
        .OUT_CREDITS ( OUT_CREDITS ),
        .RESET_PC    ( RESET_PC    )
    ) u_core_top (
        .clk            ( clk            ),
        .rst_n_i        ( rst_n_i        ),
        .inst_valid_i   ( inst_valid_i   ),
        .inst_i         ( inst_i         ),
        .credit_i       ( credit_i       ),
        .credit_o       ( credit_o       ),
        .commit_valid_o ( commit_valid_o ),
        .commit_o       ( commit_o       )
    );

    always #4 clk = ~clk;

    // ******************************
    // compare tasks
    // ******************************
    task automatic check_commit(input core_pkg::commit_t got, input core_pkg::commit_t exp);
        core_pkg::commit_t g;
        core_pkg::commit_t e;
        g = got;
        e = exp;
        // wdata means nothing without a write
        if (!e.rd_we) begin
            g.wdata = '0;
            e.wdata = '0;
        end
        checks++;
        if (g !== e) begin
            errors++;
            $display("ERROR commit_o got pc=%h inst=%h rd_we=%h rd=%h wdata=%h",
                     got.pc, got.inst, got.rd_we, got.rd, got.wdata);
            $display("ERROR commit_o exp pc=%h inst=%h rd_we=%h rd=%h wdata=%h",
                     exp.pc, exp.inst, exp.rd_we, exp.rd, exp.wdata);
        end
    endtask

    task automatic check_credits(input string what, input int got, input int exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h", what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h", what, got, exp);
        end
    endtask

    // ******************************
    // monitors
    // ******************************
    always @(posedge clk) begin
        if (rst_n_i) begin
            if (credit_o) begin
                returned++;
                if (returned > accepted) begin
                    errors++;
                    $display("credit_o pulsed with no instruction outstanding");
                end
            end
            if (inst_valid_i) begin
                accepted++;
                if (accepted - returned > QUEUE_DEPTH) begin
                    errors++;
                    $display("sender pushed with no input credit left, %0d outstanding",
                             accepted - returned);
                end
            end
            if (commit_valid_o) begin
                commits++;
                owed++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("commit seen with no instruction expected, pc %h", commit_o.pc);
                end else begin
                    check_commit(commit_o, exp_q.pop_front());
                end
            end
        end
    end

    // one credit back per commit, unless withheld
    always @(negedge clk) begin
        if (rst_n_i && auto_return && owed > 0) begin
            credit_i = 1'b1;
            owed--;
        end else begin
            credit_i = 1'b0;
        end
    end

    // ******************************
    // reference model and stimulus
    // ******************************
    task automatic model_inst(input core_pkg::inst_t inst);
        core_pkg::commit_t rec;
        logic [6:0]        opc;
        logic [2:0]        f3;
        logic [6:0]        f7;
        core_pkg::xlen_t   a;
        core_pkg::xlen_t   b;
        logic              known;
        opc       = inst[6:0];
        f3        = inst[14:12];
        f7        = inst[31:25];
        a         = model_regs[inst[19:15]];
        b         = model_regs[inst[24:20]];
        known     = 1'b0;
        rec.wdata = '0;
        if (opc == core_pkg::OPC_LUI) begin
            known     = 1'b1;
            rec.wdata = {{32{inst[31]}}, inst[31:12], 12'h000};
        end else if (opc == core_pkg::OPC_OP_IMM && f3 == 3'b000) begin
            known     = 1'b1;
            rec.wdata = a + {{52{inst[31]}}, inst[31:20]};
        end else if (opc == core_pkg::OPC_OP && f7 == 7'h20 && f3 == 3'b000) begin
            known     = 1'b1;
            rec.wdata = a - b;
        end else if (opc == core_pkg::OPC_OP && f7 == 7'h00) begin
            known = 1'b1;
            case (f3)
                3'b000:  rec.wdata = a + b;
                3'b001:  rec.wdata = a << b[5:0];
                3'b010:  rec.wdata = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                3'b100:  rec.wdata = a ^ b;
                3'b101:  rec.wdata = a >> b[5:0];
                3'b110:  rec.wdata = a | b;
                3'b111:  rec.wdata = a & b;
                default: known = 1'b0;
            endcase
        end
        rec.pc    = model_pc;
        rec.inst  = inst;
        rec.rd    = inst[11:7];
        rec.rd_we = known && (inst[11:7] != 5'd0);
        if (rec.rd_we) begin
            model_regs[rec.rd] = rec.wdata;
        end
        model_pc = model_pc + 64'd4;
        exp_q.push_back(rec);
    endtask

    function automatic core_pkg::inst_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                              input core_pkg::reg_addr_t rd,
                                              input core_pkg::reg_addr_t rs1,
                                              input core_pkg::reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic core_pkg::inst_t enc_i(input logic [11:0] imm,
                                              input core_pkg::reg_addr_t rs1,
                                              input logic [2:0] f3,
                                              input core_pkg::reg_addr_t rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic core_pkg::inst_t enc_u(input logic [19:0] imm,
                                              input core_pkg::reg_addr_t rd);
        return {imm, rd, 7'b0110111};
    endfunction

    // never x0
    function automatic core_pkg::reg_addr_t rand_reg();
        return 5'(1 + ($unsigned($random(seed)) % 31));
    endfunction

    function automatic logic [11:0] rand_imm12();
        return 12'($random(seed));
    endfunction

    function automatic logic [19:0] rand_imm20();
        return 20'($random(seed));
    endfunction

    task automatic send_inst(input core_pkg::inst_t inst);
        while (QUEUE_DEPTH + returned - sent <= 0) begin
            @(negedge clk);
        end
        model_inst(inst);
        inst_valid_i = 1'b1;
        inst_i       = inst;
        sent++;
        @(negedge clk);
        inst_valid_i = 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while ((exp_q.size() != 0 || owed != 0) && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("pipeline did not drain, %0d commits never arrived", exp_q.size());
            exp_q.delete();
        end
        @(negedge clk);
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    `include "core_tb_tests.svh"

    initial begin
        #(WATCHDOG_NS);
        $display("timeout, the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        credit_i     = 1'b0;
        auto_return  = 1'b1;
        model_pc     = RESET_PC;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        reset_behavior();
        addi_stream();
        dependent_chain();
        x0_and_unsupported();
        output_backpressure();
        input_credit_stream();
        $display("checks %0d, errors %0d, commits %0d, instructions %0d",
                 checks, errors, commits, sent);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+verification
logic/core_pkg.sv
logic/reg_file.sv
logic/inst_queue.sv
logic/decode_stage.sv
logic/alu_stage.sv
logic/commit_port.sv
logic/core_top.sv
verification/core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f vlog.f --top-module core_tb -o core_tb_sim

sim_out=$(./obj_dir/core_tb_sim)
echo "$sim_out"

if grep -qx "ALL CHECKS PASSED" <<< "$sim_out"; then
    exit 0
fi
exit 1
